// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_ex_stage
FILELIST  ?= ex_stage.f
OBJ_DIR   ?= obj_dir

.PHONY: sim clean

# build and run, the exit status of the binary is the result
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: ex_stage.f
+incdir+hdl
hdl/ex_pkg.sv
hdl/ex_alu.sv
hdl/ex_mult.sv
hdl/ex_stage.sv
sim/tb_clkgen.sv
sim/tb_ex_stage.sv

// File: hdl/ex_alu.sv
// single-cycle integer ALU with arithmetic, logic, shift and compare operations
`timescale 1ns/1ps
`include "ex_macros.svh"

module ex_alu import ex_pkg::*; (
    // only used to sample the assertions
    input  logic               clk,
    input  logic               rst_n,

    input  logic               enable_i,
    input  alu_op_e            operator_i,
    input  logic [`XLEN-1:0]   operand_a_i,
    input  logic [`XLEN-1:0]   operand_b_i,

    output logic [`XLEN-1:0]   result_o,
    output logic               comparison_result_o,

    output logic               ready_o,
    input  logic               ex_ready_i
);

    localparam int SHAMT_W = $clog2(`XLEN);

    logic [SHAMT_W-1:0]  shamt;
    logic                is_equal;
    logic                is_less;
    logic                is_less_u;
    logic                cmp_result;

    // ==================================================================
    // comparator
    // ==================================================================

    assign is_equal  = (operand_a_i == operand_b_i);
    assign is_less   = ($signed(operand_a_i) < $signed(operand_b_i));
    assign is_less_u = (operand_a_i < operand_b_i);

    // condition per operator, 0 for non-compare ops
    always_comb begin
        case (operator_i)
            ALU_EQ:            cmp_result = is_equal;
            ALU_NE:            cmp_result = ~is_equal;
            ALU_LT, ALU_SLT:   cmp_result = is_less;
            ALU_GE:            cmp_result = ~is_less;
            ALU_LTU, ALU_SLTU: cmp_result = is_less_u;
            ALU_GEU:           cmp_result = ~is_less_u;
            default:           cmp_result = 1'b0;
        endcase
    end

    // branch decision goes straight out
    assign comparison_result_o = cmp_result;

    // ==================================================================
    // result mux
    // ==================================================================

    // shift amount, only low bits count
    assign shamt = operand_b_i[SHAMT_W-1:0];

    always_comb begin
        case (operator_i)
            ALU_ADD: result_o = operand_a_i + operand_b_i;
            ALU_SUB: result_o = operand_a_i - operand_b_i;
            ALU_AND: result_o = operand_a_i & operand_b_i;
            ALU_OR:  result_o = operand_a_i | operand_b_i;
            ALU_XOR: result_o = operand_a_i ^ operand_b_i;
            ALU_SLL: result_o = operand_a_i << shamt;
            ALU_SRL: result_o = operand_a_i >> shamt;
            // arithmetic shift keeps the sign bit
            ALU_SRA: result_o = $signed(operand_a_i) >>> shamt;
            // compares give a 0/1 word
            ALU_SLT, ALU_SLTU,
            ALU_EQ, ALU_NE, ALU_LT, ALU_GE, ALU_LTU, ALU_GEU:
                result_o = {{(`XLEN-1){1'b0}}, cmp_result};
            default: result_o = '0;
        endcase
    end

    // no internal state, always done in one cycle
    assign ready_o = 1'b1;

    // ==================================================================
    // assertions
    // ==================================================================

    // decode only issues known operator encodings
    a_legal_op: assert property (
        @(posedge clk) disable iff (!rst_n)
        enable_i |-> (!$isunknown(operator_i) &&
                      operator_i inside {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
                                         ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU,
                                         ALU_EQ, ALU_NE, ALU_LT, ALU_GE, ALU_LTU,
                                         ALU_GEU})
    ) else $error("ex_alu: illegal operator %0d", operator_i);

    // stalled instruction is held by decode until the stage accepts it
    a_hold_on_stall: assert property (
        @(posedge clk) disable iff (!rst_n)
        (enable_i && !ex_ready_i) |=> (enable_i && $stable(operator_i))
    ) else $error("ex_alu: instruction changed while stalled");

endmodule

// File: hdl/ex_macros.svh
// execute stage widths and multiplier latency, shared by RTL and testbench
`ifndef EX_MACROS_SVH
`define EX_MACROS_SVH

// ======================================================================
// data path
// ======================================================================

// integer register width, RV32
`define XLEN 32

// register file address, 32 entries
`define RF_ADDR_W 5

// ======================================================================
// multiplier
// ======================================================================

// edges from first accepted multiply cycle until ready goes high
// one edge to register operands, one to form the product
`define MULT_CYCLES 2

`endif

// File: hdl/ex_mult.sv
// multi-cycle 32x32 multiplier returning the low or high product word
`timescale 1ns/1ps
`include "ex_macros.svh"

module ex_mult import ex_pkg::*; (
    input  logic               clk,
    input  logic               rst_n,

    input  logic               enable_i,
    input  mult_op_e           operator_i,
    input  logic [`XLEN-1:0]   op_a_i,
    input  logic [`XLEN-1:0]   op_b_i,

    output logic [`XLEN-1:0]   result_o,

    output logic               ready_o,
    input  logic               ready_i
);

    // controller states
    typedef enum logic [1:0] {
        MULT_IDLE    = 2'd0,
        MULT_PRODUCT = 2'd1,
        MULT_DONE    = 2'd2
    } mult_state_e;

    mult_state_e              state_q;
    mult_state_e              state_d;

    // operands captured on the first cycle
    mult_op_e                 op_q;
    logic [`XLEN-1:0]         op_a_q;
    logic [`XLEN-1:0]         op_b_q;
    logic [`XLEN-1:0]         result_q;

    logic                     signed_a;
    logic                     signed_b;
    logic signed [`XLEN:0]    op_a_ext;
    logic signed [`XLEN:0]    op_b_ext;
    logic signed [2*`XLEN+1:0] product_full;
    logic [2*`XLEN-1:0]       product;

    // ==================================================================
    // controller
    // ==================================================================

    always_comb begin
        state_d = state_q;
        case (state_q)
            MULT_IDLE:    if (enable_i) state_d = MULT_PRODUCT;
            MULT_PRODUCT: state_d = MULT_DONE;
            // wait for the stage to take the result
            MULT_DONE:    if (ready_i) state_d = MULT_IDLE;
            default:      state_d = MULT_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= MULT_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // ready drops on the very first enable cycle
    assign ready_o = (state_q == MULT_DONE) ||
                     ((state_q == MULT_IDLE) && !enable_i);

    // ==================================================================
    // datapath
    // ==================================================================

    always_ff @(posedge clk) begin
        if ((state_q == MULT_IDLE) && enable_i) begin
            op_q   <= operator_i;
            op_a_q <= op_a_i;
            op_b_q <= op_b_i;
        end
    end

    // signedness from the operator
    assign signed_a = (op_q == MULT_MULH) || (op_q == MULT_MULHSU);
    assign signed_b = (op_q == MULT_MULH);

    // one extra bit covers both signed and unsigned operands
    assign op_a_ext = {signed_a & op_a_q[`XLEN-1], op_a_q};
    assign op_b_ext = {signed_b & op_b_q[`XLEN-1], op_b_q};

    assign product_full = op_a_ext * op_b_ext;
    assign product      = product_full[2*`XLEN-1:0];

    // pick the word at the end of the product state
    always_ff @(posedge clk) begin
        if (state_q == MULT_PRODUCT) begin
            if (op_q == MULT_MUL) begin
                result_q <= product[`XLEN-1:0];
            end else begin
                result_q <= product[2*`XLEN-1:`XLEN];
            end
        end
    end

    assign result_o = result_q;

    // ==================================================================
    // assertions
    // ==================================================================

    // finished result is held while the stage is stalled
    a_result_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        ((state_q == MULT_DONE) && !ready_i) |=> $stable(result_o)
    ) else $error("ex_mult: result changed while stalled");

    // decode must keep the multiply until it completes
    a_enable_held: assert property (
        @(posedge clk) disable iff (!rst_n)
        (state_q != MULT_IDLE) |-> enable_i
    ) else $error("ex_mult: enable dropped before completion");

endmodule

// File: hdl/ex_pkg.sv
// execute stage operator encodings for the ALU and the multiplier
package ex_pkg;

    // ALU operators
    // arithmetic and logic first, then shifts, then compares
    typedef enum logic [4:0] {
        ALU_ADD  = 5'd0,
        ALU_SUB  = 5'd1,
        ALU_AND  = 5'd2,
        ALU_OR   = 5'd3,
        ALU_XOR  = 5'd4,
        // shifts, amount from operand b low bits
        ALU_SLL  = 5'd5,
        ALU_SRL  = 5'd6,
        ALU_SRA  = 5'd7,
        // set-less-than, 0/1 result
        ALU_SLT  = 5'd8,
        ALU_SLTU = 5'd9,
        // branch compares
        ALU_EQ   = 5'd10,
        ALU_NE   = 5'd11,
        ALU_LT   = 5'd12,
        ALU_GE   = 5'd13,
        ALU_LTU  = 5'd14,
        ALU_GEU  = 5'd15
    } alu_op_e;

    // multiplier operators
    // operand signedness is implied by the operator
    //   MUL    low word, sign irrelevant
    //   MULH   high word, signed x signed
    //   MULHSU high word, signed x unsigned
    //   MULHU  high word, unsigned x unsigned
    typedef enum logic [1:0] {
        MULT_MUL    = 2'd0,
        MULT_MULH   = 2'd1,
        MULT_MULHSU = 2'd2,
        MULT_MULHU  = 2'd3
    } mult_op_e;

endpackage

// File: hdl/ex_stage.sv
// execute stage top: ALU, multiplier, forward mux, EX/WB register, stall logic
`timescale 1ns/1ps
`include "ex_macros.svh"

module ex_stage import ex_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,

    // ALU instruction from decode
    input  alu_op_e                alu_operator_i,
    input  logic [`XLEN-1:0]       alu_operand_a_i,
    input  logic [`XLEN-1:0]       alu_operand_b_i,
    input  logic [`XLEN-1:0]       alu_operand_c_i,
    input  logic                   alu_en_i,

    // multiply instruction from decode
    input  mult_op_e               mult_operator_i,
    input  logic [`XLEN-1:0]       mult_operand_a_i,
    input  logic [`XLEN-1:0]       mult_operand_b_i,
    input  logic                   mult_en_i,

    // load/store unit
    input  logic                   lsu_en_i,
    input  logic [`XLEN-1:0]       lsu_rdata_i,
    input  logic                   lsu_ready_ex_i,

    // branch and jump
    input  logic                   branch_in_ex_i,
    output logic                   branch_decision_o,
    output logic [`XLEN-1:0]       jump_target_o,

    // write-back destinations from decode
    input  logic                   regfile_we_i,
    input  logic [`RF_ADDR_W-1:0]  regfile_waddr_i,
    input  logic                   regfile_alu_we_i,
    input  logic [`RF_ADDR_W-1:0]  regfile_alu_waddr_i,

    // CSR read value
    input  logic                   csr_access_i,
    input  logic [`XLEN-1:0]       csr_rdata_i,

    // load write-back, EX/WB register
    output logic [`RF_ADDR_W-1:0]  regfile_waddr_wb_o,
    output logic                   regfile_we_wb_o,
    output logic [`XLEN-1:0]       regfile_wdata_wb_o,

    // forward path to decode and register file
    output logic [`RF_ADDR_W-1:0]  regfile_alu_waddr_fw_o,
    output logic                   regfile_alu_we_fw_o,
    output logic [`XLEN-1:0]       regfile_alu_wdata_fw_o,

    // stall handshake
    output logic                   ex_ready_o,
    output logic                   ex_valid_o,
    input  logic                   wb_ready_i
);

    logic [`XLEN-1:0]  alu_result;
    logic              alu_cmp_result;
    logic              alu_ready;
    logic [`XLEN-1:0]  mult_result;
    logic              mult_ready;
    logic              units_ready;
    logic              any_en;

    // ==================================================================
    // functional units
    // ==================================================================

    ex_alu u_alu (
        .clk                 (clk),
        .rst_n               (rst_n),
        .enable_i            (alu_en_i),
        .operator_i          (alu_operator_i),
        .operand_a_i         (alu_operand_a_i),
        .operand_b_i         (alu_operand_b_i),
        .result_o            (alu_result),
        .comparison_result_o (alu_cmp_result),
        .ready_o             (alu_ready),
        .ex_ready_i          (ex_ready_o)
    );

    ex_mult u_mult (
        .clk        (clk),
        .rst_n      (rst_n),
        .enable_i   (mult_en_i),
        .operator_i (mult_operator_i),
        .op_a_i     (mult_operand_a_i),
        .op_b_i     (mult_operand_b_i),
        .result_o   (mult_result),
        .ready_o    (mult_ready),
        .ready_i    (ex_ready_o)
    );

    // branch outcome straight from the comparator
    assign branch_decision_o = alu_cmp_result;
    // target already computed by decode, carried in operand c
    assign jump_target_o     = alu_operand_c_i;

    // forward mux, enables are one-hot
    always_comb begin
        if (alu_en_i) begin
            regfile_alu_wdata_fw_o = alu_result;
        end else if (mult_en_i) begin
            regfile_alu_wdata_fw_o = mult_result;
        end else if (csr_access_i) begin
            regfile_alu_wdata_fw_o = csr_rdata_i;
        end else begin
            regfile_alu_wdata_fw_o = '0;
        end
    end

    assign regfile_alu_we_fw_o    = regfile_alu_we_i;
    assign regfile_alu_waddr_fw_o = regfile_alu_waddr_i;

    // ==================================================================
    // stall logic
    // ==================================================================

    assign units_ready = alu_ready & mult_ready & lsu_ready_ex_i & wb_ready_i;
    assign any_en      = alu_en_i | mult_en_i | csr_access_i | lsu_en_i;

    // branches resolve here, no need to wait for write-back
    assign ex_ready_o = units_ready | branch_in_ex_i;
    assign ex_valid_o = any_en & units_ready;

    // ==================================================================
    // EX/WB register
    // ==================================================================

    // write enable is control
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            regfile_we_wb_o <= 1'b0;
        end else if (ex_valid_o) begin
            regfile_we_wb_o <= regfile_we_i;
        end else if (wb_ready_i) begin
            // bubble, drain the old entry
            regfile_we_wb_o <= 1'b0;
        end
    end

    // address and load data only when a write follows
    always_ff @(posedge clk) begin
        if (ex_valid_o && regfile_we_i) begin
            regfile_waddr_wb_o <= regfile_waddr_i;
            regfile_wdata_wb_o <= lsu_rdata_i;
        end
    end

    // ==================================================================
    // assertions
    // ==================================================================

    // decode issues to one unit at a time
    a_one_enable: assert property (
        @(posedge clk) disable iff (!rst_n)
        $onehot0({alu_en_i, mult_en_i, csr_access_i, lsu_en_i})
    ) else $error("ex_stage: more than one unit enabled");

endmodule

// File: sim/tb_clkgen.sv
// testbench clock and reset source, 10 ns clock and active low reset
`timescale 1ns/1ps

module tb_clkgen #(
    parameter int PERIOD_NS    = 10,
    parameter int RESET_CYCLES = 8
) (
    output logic clk_o,
    output logic rst_n_o
);

    // free running clock
    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // reset held low for a fixed number of edges, released off the edge
    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #1 rst_n_o = 1'b1;
    end

endmodule

// File: sim/tb_ex_stage.sv
// directed testbench for the execute stage: ALU, branch, multiply, stall and write-back
`timescale 1ns/1ps
`include "ex_macros.svh"

module tb_ex_stage import ex_pkg::*; ();

    localparam logic [31:0] LFSR_SEED      = 32'h46ed5adc;
    // taps 32, 22, 2, 1
    localparam logic [31:0] LFSR_TAPS      = 32'h80200003;
    localparam int          TIMEOUT_CYCLES = 100;
    localparam int          DRIVE_DLY      = 1;
    localparam int          RAND_PAIRS     = 4;

    logic                  clk;
    logic                  rst_n;
    alu_op_e               alu_operator_i;
    logic [`XLEN-1:0]      alu_operand_a_i, alu_operand_b_i, alu_operand_c_i;
    logic                  alu_en_i;
    mult_op_e              mult_operator_i;
    logic [`XLEN-1:0]      mult_operand_a_i, mult_operand_b_i;
    logic                  mult_en_i;
    logic                  lsu_en_i, lsu_ready_ex_i, branch_in_ex_i;
    logic [`XLEN-1:0]      lsu_rdata_i;
    logic                  regfile_we_i, regfile_alu_we_i;
    logic [`RF_ADDR_W-1:0] regfile_waddr_i, regfile_alu_waddr_i;
    logic                  csr_access_i, wb_ready_i;
    logic [`XLEN-1:0]      csr_rdata_i;
    logic                  branch_decision_o;
    logic [`XLEN-1:0]      jump_target_o;
    logic [`RF_ADDR_W-1:0] regfile_waddr_wb_o, regfile_alu_waddr_fw_o;
    logic                  regfile_we_wb_o, regfile_alu_we_fw_o;
    logic [`XLEN-1:0]      regfile_wdata_wb_o, regfile_alu_wdata_fw_o;
    logic                  ex_ready_o, ex_valid_o;
    logic [31:0]           lfsr_state;

    tb_clkgen u_clkgen (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    // port names match the signals above
    ex_stage i_dut (.*);

    // ==================================================================
    // stimulus source and reference models
    // ==================================================================

    // galois LFSR, one step per bit
    function automatic logic lfsr_bit();
        logic out;
        out = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out) begin
            lfsr_state = lfsr_state ^ LFSR_TAPS;
        end
        return out;
    endfunction

    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_bit()};
        end
        return v;
    endfunction

    function automatic logic cond_ref(input alu_op_e op, input logic [`XLEN-1:0] a,
                                      input logic [`XLEN-1:0] b);
        logic lt_s;
        logic lt_u;
        lt_u = a < b;
        // flipped sign bits make the signed order an unsigned one
        lt_s = (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000);
        case (op)
            ALU_EQ:  return a == b;
            ALU_NE:  return a != b;
            ALU_LT:  return lt_s;
            ALU_GE:  return !lt_s;
            ALU_LTU: return lt_u;
            ALU_GEU: return !lt_u;
            default: return 1'b0;
        endcase
    endfunction

    function automatic logic [`XLEN-1:0] alu_ref(input alu_op_e op, input logic [`XLEN-1:0] a,
                                                 input logic [`XLEN-1:0] b);
        logic [4:0]       sh;
        logic [`XLEN-1:0] fill;
        sh = b[4:0];
        // sign fill for the arithmetic shift
        fill = a[`XLEN-1] ? ~({`XLEN{1'b1}} >> sh) : '0;
        case (op)
            ALU_ADD:  return a + b;
            ALU_SUB:  return a - b;
            ALU_AND:  return a & b;
            ALU_OR:   return a | b;
            ALU_XOR:  return a ^ b;
            ALU_SLL:  return a << sh;
            ALU_SRL:  return a >> sh;
            ALU_SRA:  return (a >> sh) | fill;
            ALU_SLT:  return {{(`XLEN-1){1'b0}}, cond_ref(ALU_LT, a, b)};
            ALU_SLTU: return {{(`XLEN-1){1'b0}}, cond_ref(ALU_LTU, a, b)};
            default:  return '0;
        endcase
    endfunction

    // 64 bit extension, low 64 bits of the product are exact
    function automatic logic [`XLEN-1:0] mult_ref(input mult_op_e op, input logic [`XLEN-1:0] a,
                                                  input logic [`XLEN-1:0] b);
        logic [2*`XLEN-1:0] a_ext;
        logic [2*`XLEN-1:0] b_ext;
        logic [2*`XLEN-1:0] prod;
        a_ext = {{`XLEN{(op == MULT_MULH || op == MULT_MULHSU) && a[`XLEN-1]}}, a};
        b_ext = {{`XLEN{(op == MULT_MULH) && b[`XLEN-1]}}, b};
        prod  = a_ext * b_ext;
        return (op == MULT_MUL) ? prod[`XLEN-1:0] : prod[2*`XLEN-1:`XLEN];
    endfunction

    // ==================================================================
    // checks, timing helpers
    // ==================================================================

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1, "stopped on first error");
    endtask

    task automatic expect_word(input string name, input logic [`XLEN-1:0] got,
                               input logic [`XLEN-1:0] exp);
        assert (got === exp) else
            abort_run($sformatf("Mismatch at %0t ns: %s is %h, expected %h",
                                $time, name, got, exp));
    endtask

    task automatic expect_bit(input string name, input logic got, input logic exp);
        assert (got === exp) else
            abort_run($sformatf("Mismatch at %0t ns: %s is %b, expected %b",
                                $time, name, got, exp));
    endtask

    // inputs change just after the edge, outputs read mid cycle
    task automatic to_drive_point();
        @(posedge clk);
        #DRIVE_DLY;
    endtask

    task automatic to_sample_point();
        @(negedge clk);
    endtask

    task automatic drive_idle();
        alu_operator_i      = ALU_ADD;
        alu_operand_a_i     = '0;
        alu_operand_b_i     = '0;
        alu_operand_c_i     = '0;
        alu_en_i            = 1'b0;
        mult_operator_i     = MULT_MUL;
        mult_operand_a_i    = '0;
        mult_operand_b_i    = '0;
        mult_en_i           = 1'b0;
        lsu_en_i            = 1'b0;
        lsu_rdata_i         = '0;
        lsu_ready_ex_i      = 1'b1;
        branch_in_ex_i      = 1'b0;
        regfile_we_i        = 1'b0;
        regfile_waddr_i     = '0;
        regfile_alu_we_i    = 1'b0;
        regfile_alu_waddr_i = '0;
        csr_access_i        = 1'b0;
        csr_rdata_i         = '0;
        wb_ready_i          = 1'b1;
    endtask

    task automatic wait_for_reset();
        int n;
        n = 0;
        while (rst_n !== 1'b1 && n < TIMEOUT_CYCLES) begin
            @(posedge clk);
            n++;
        end
        if (rst_n !== 1'b1) begin
            abort_run($sformatf("Timeout: reset still active after %0d cycles", n));
        end
    endtask

    // counts mid-cycle samples from the issue cycle until valid
    task automatic wait_for_valid(output int cycles);
        cycles = 0;
        @(negedge clk);
        while (ex_valid_o !== 1'b1 && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            cycles++;
        end
        if (ex_valid_o !== 1'b1) begin
            abort_run($sformatf("Timeout at %0t ns: ex_valid_o stayed low for %0d cycles",
                                $time, TIMEOUT_CYCLES));
        end
    endtask

    // ==================================================================
    // directed tests
    // ==================================================================

    // arithmetic, logic, shift and set-less-than, forwarded same cycle
    task automatic alu_op_sweep();
        alu_op_e op;
        for (int i = 0; i <= 9; i++) begin
            for (int k = 0; k < RAND_PAIRS; k++) begin
                to_drive_point();
                op = alu_op_e'(i);
                alu_en_i            = 1'b1;
                alu_operator_i      = op;
                alu_operand_a_i     = random_bits(`XLEN);
                alu_operand_b_i     = random_bits(`XLEN);
                regfile_alu_we_i    = lfsr_bit();
                regfile_alu_waddr_i = `RF_ADDR_W'(random_bits(`RF_ADDR_W));
                to_sample_point();
                expect_word("regfile_alu_wdata_fw_o", regfile_alu_wdata_fw_o,
                            alu_ref(op, alu_operand_a_i, alu_operand_b_i));
                expect_bit("ex_valid_o", ex_valid_o, 1'b1);
                expect_bit("regfile_alu_we_fw_o", regfile_alu_we_fw_o, regfile_alu_we_i);
                expect_word("regfile_alu_waddr_fw_o", `XLEN'(regfile_alu_waddr_fw_o),
                            `XLEN'(regfile_alu_waddr_i));
            end
        end
        to_drive_point();
        drive_idle();
    endtask

    // branch compares under write-back stall, last pair has equal operands
    task automatic branch_compare_sweep();
        alu_op_e op;
        for (int i = 10; i <= 15; i++) begin
            for (int k = 0; k < 3; k++) begin
                to_drive_point();
                op = alu_op_e'(i);
                alu_en_i        = 1'b1;
                alu_operator_i  = op;
                branch_in_ex_i  = 1'b1;
                wb_ready_i      = 1'b0;
                alu_operand_a_i = random_bits(`XLEN);
                alu_operand_b_i = (k < 2) ? random_bits(`XLEN) : alu_operand_a_i;
                alu_operand_c_i = random_bits(`XLEN);
                to_sample_point();
                expect_bit("branch_decision_o", branch_decision_o,
                           cond_ref(op, alu_operand_a_i, alu_operand_b_i));
                expect_word("jump_target_o", jump_target_o, alu_operand_c_i);
                expect_bit("ex_ready_o", ex_ready_o, 1'b1);
                expect_bit("ex_valid_o", ex_valid_o, 1'b0);
            end
        end
        to_drive_point();
        drive_idle();
    endtask

    task automatic multiply_once(input mult_op_e op, input logic [`XLEN-1:0] a,
                                 input logic [`XLEN-1:0] b);
        int cycles;
        to_drive_point();
        mult_en_i        = 1'b1;
        mult_operator_i  = op;
        mult_operand_a_i = a;
        mult_operand_b_i = b;
        regfile_alu_we_i = 1'b1;
        wait_for_valid(cycles);
        expect_word("ex_valid_o latency", `XLEN'(cycles), `MULT_CYCLES);
        expect_word("regfile_alu_wdata_fw_o", regfile_alu_wdata_fw_o, mult_ref(op, a, b));
        to_drive_point();
        drive_idle();
    endtask

    // all four operators, random and corner operands
    task automatic multiply_sweep();
        logic [`XLEN-1:0] corners [4];
        logic [`XLEN-1:0] r;
        mult_op_e         op;
        corners = '{32'h0000_0000, 32'hffff_ffff, 32'h8000_0000, 32'h7fff_ffff};
        for (int i = 0; i < 4; i++) begin
            op = mult_op_e'(i);
            for (int k = 0; k < RAND_PAIRS; k++) begin
                r = random_bits(`XLEN);
                multiply_once(op, r, random_bits(`XLEN));
            end
            for (int j = 0; j < 4; j++) begin
                r = random_bits(`XLEN);
                multiply_once(op, corners[j], r);
                multiply_once(op, r, corners[j]);
                for (int k = 0; k < 4; k++) begin
                    multiply_once(op, corners[j], corners[k]);
                end
            end
        end
    endtask

    // finished multiply must wait for write-back
    task automatic backpressure_multiply();
        mult_op_e op;
        to_drive_point();
        op = mult_op_e'(random_bits(2));
        mult_en_i        = 1'b1;
        mult_operator_i  = op;
        mult_operand_a_i = random_bits(`XLEN);
        mult_operand_b_i = random_bits(`XLEN);
        wb_ready_i       = 1'b0;
        for (int n = 0; n < 10; n++) begin
            to_sample_point();
            expect_bit("ex_valid_o", ex_valid_o, 1'b0);
            expect_bit("ex_ready_o", ex_ready_o, 1'b0);
        end
        to_drive_point();
        wb_ready_i = 1'b1;
        to_sample_point();
        expect_bit("ex_valid_o", ex_valid_o, 1'b1);
        expect_word("regfile_alu_wdata_fw_o", regfile_alu_wdata_fw_o,
                    mult_ref(op, mult_operand_a_i, mult_operand_b_i));
        to_drive_point();
        drive_idle();
    endtask

    task automatic csr_and_load_writeback();
        logic [`RF_ADDR_W-1:0] addr;
        logic [`XLEN-1:0]      data;
        // CSR read goes out on the forward path
        to_drive_point();
        csr_access_i = 1'b1;
        csr_rdata_i  = random_bits(`XLEN);
        to_sample_point();
        expect_word("regfile_alu_wdata_fw_o", regfile_alu_wdata_fw_o, csr_rdata_i);
        expect_bit("ex_valid_o", ex_valid_o, 1'b1);
        // load, EX/WB register fills at the end of this cycle
        to_drive_point();
        drive_idle();
        addr = `RF_ADDR_W'(random_bits(`RF_ADDR_W));
        data = random_bits(`XLEN);
        lsu_en_i        = 1'b1;
        regfile_we_i    = 1'b1;
        regfile_waddr_i = addr;
        lsu_rdata_i     = data;
        to_sample_point();
        expect_bit("ex_valid_o", ex_valid_o, 1'b1);
        expect_bit("regfile_we_wb_o", regfile_we_wb_o, 1'b0);
        to_drive_point();
        drive_idle();
        to_sample_point();
        expect_bit("regfile_we_wb_o", regfile_we_wb_o, 1'b1);
        expect_word("regfile_waddr_wb_o", `XLEN'(regfile_waddr_wb_o), `XLEN'(addr));
        expect_word("regfile_wdata_wb_o", regfile_wdata_wb_o, data);
        // bubble drains the write enable
        to_drive_point();
        to_sample_point();
        expect_bit("regfile_we_wb_o", regfile_we_wb_o, 1'b0);
    endtask

    // ==================================================================
    // main sequence
    // ==================================================================

    initial begin
        lfsr_state = LFSR_SEED;
        drive_idle();
        wait_for_reset();
        to_sample_point();
        expect_bit("regfile_we_wb_o", regfile_we_wb_o, 1'b0);
        expect_bit("ex_valid_o", ex_valid_o, 1'b0);
        expect_bit("ex_ready_o", ex_ready_o, 1'b1);
        alu_op_sweep();
        branch_compare_sweep();
        multiply_sweep();
        backpressure_multiply();
        csr_and_load_writeback();
        $display("Simulation completed successfully");
        $finish;
    end

endmodule
